//--- Makefile
# Verilator build and run of the keypad testbench
TOP := tb_keypad

.PHONY: compile run clean

compile:
	verilator --binary --timing --top-module $(TOP) -f filelist.f -o $(TOP)

# The run passes only when the pass line shows up in the output
run: compile
	@out="$$(./obj_dir/$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "Regression passed"

clean:
	rm -rf obj_dir

//--- filelist.f
rtl/keypad_pkg.sv
rtl/keypad_row_filter.sv
rtl/keypad_scanner.sv
rtl/key_queue.sv
rtl/keypad_top.sv
sim/tb_clock.sv
sim/tb_keypad.sv

//--- rtl/key_queue.sv
`timescale 1ns/1ps
`default_nettype none

module key_queue
    import keypad_pkg::*;
(
    input  wire logic      clk,
    input  wire logic      nRST,
    input  wire logic      push,
    input  wire key_char_t push_char,
    output logic           key_valid,
    output key_char_t      key_char,
    input  wire logic      credit_return,
    output logic           overflow
);

    // ------------------------------------------------------------------
    // Storage and pointers
    // ------------------------------------------------------------------

    key_char_t             mem [QUEUE_DEPTH];
    logic [QPTR_W-1:0]     wr_ptr;
    logic [QPTR_W-1:0]     rd_ptr;
    logic [QCNT_W-1:0]     fill;
    credit_cnt_t           credits;

    logic                  full;
    logic                  empty;
    logic                  send;
    logic                  accept;

    assign full  = (fill == QCNT_W'(QUEUE_DEPTH));
    assign empty = (fill == '0);

    // A send needs a character and a credit
    assign send = !empty && (credits != '0);

    // A send in the same cycle frees a slot for a push to a full queue
    assign accept = push && (!full || send);

    assign key_valid = send;
    assign key_char  = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (accept) begin
            mem[wr_ptr] <= push_char;
        end
    end

    always_ff @(posedge clk, negedge nRST) begin
        if (!nRST) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            fill   <= '0;
        end else begin
            if (accept) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (send) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({accept, send})
                2'b10:   fill <= fill + 1'b1;
                2'b01:   fill <= fill - 1'b1;
                default: fill <= fill;
            endcase
        end
    end

    // ------------------------------------------------------------------
    // Credits and overflow
    // ------------------------------------------------------------------

    always_ff @(posedge clk, negedge nRST) begin
        if (!nRST) begin
            credits <= credit_cnt_t'(SINK_CREDITS);
        end else begin
            case ({send, credit_return})
                2'b10: credits <= credits - 1'b1;
                2'b01: begin
                    // The consumer never holds more than it was granted
                    if (credits != credit_cnt_t'(SINK_CREDITS)) begin
                        credits <= credits + 1'b1;
                    end
                end
                default: credits <= credits;
            endcase
        end
    end

    // Sticky until reset
    always_ff @(posedge clk, negedge nRST) begin
        if (!nRST) begin
            overflow <= 1'b0;
        end else if (push && !accept) begin
            overflow <= 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- rtl/keypad_pkg.sv
`default_nettype none

package keypad_pkg;

    // ------------------------------------------------------------------
    // Matrix signals and characters
    // ------------------------------------------------------------------

    // Row lines, bit i is row i, high in the row of a pressed key
    typedef logic [3:0] rows_t;

    // Column drive lines, active low, one bit low at a time while scanning
    typedef logic [3:0] cols_t;

    // Matrix position of a key as {rows, cols}
    typedef logic [7:0] key_code_t;

    // ASCII character, zero stands for no valid key
    typedef logic [7:0] key_char_t;

    // ------------------------------------------------------------------
    // Timing and sizes
    // ------------------------------------------------------------------

    // Equal synchronized samples needed before the filter output moves
    localparam int FILTER_CYCLES = 3;
    localparam int FILTER_CNT_W  = $clog2(FILTER_CYCLES);

    // Cycles each column is driven before its rows are judged
    localparam int DWELL_CYCLES = 8;
    localparam int DWELL_CNT_W  = $clog2(DWELL_CYCLES);

    // Character queue
    localparam int QUEUE_DEPTH = 4;
    localparam int QPTR_W      = $clog2(QUEUE_DEPTH);
    localparam int QCNT_W      = $clog2(QUEUE_DEPTH + 1);

    // Credits granted by the consumer after reset
    localparam int SINK_CREDITS = 2;
    localparam int CREDIT_W     = $clog2(SINK_CREDITS + 1);

    typedef logic [CREDIT_W-1:0] credit_cnt_t;

    typedef enum logic [1:0] {SCAN, HELD, RELEASE} scan_state_t;

endpackage

`default_nettype wire

//--- rtl/keypad_row_filter.sv
`timescale 1ns/1ps
`default_nettype none

module keypad_row_filter
    import keypad_pkg::*;
(
    input  wire logic  clk,
    input  wire logic  nRST,
    input  wire rows_t rows,
    output rows_t      clean_rows
);

    // ------------------------------------------------------------------
    // Synchronizer
    // ------------------------------------------------------------------

    // The keypad rows are asynchronous to clk, so two flops come first
    rows_t sync_1;
    rows_t sync_2;

    always_ff @(posedge clk, negedge nRST) begin
        if (!nRST) begin
            sync_1 <= '0;
            sync_2 <= '0;
        end else begin
            sync_1 <= rows;
            sync_2 <= sync_1;
        end
    end

    // ------------------------------------------------------------------
    // Stability filter
    // ------------------------------------------------------------------

    // Candidate holds the value being timed, stable_cnt the number of
    // equal samples seen before the current one, less one
    rows_t                   candidate;
    logic [FILTER_CNT_W-1:0] stable_cnt;
    logic                    stable_done;

    // The current sample is the last one the filter needs
    assign stable_done = (stable_cnt == FILTER_CNT_W'(FILTER_CYCLES - 2));

    always_ff @(posedge clk, negedge nRST) begin
        if (!nRST) begin
            candidate  <= '0;
            stable_cnt <= '0;
            clean_rows <= '0;
        end else begin
            if (sync_2 != candidate) begin
                // Any change restarts the count, which swallows bounce
                candidate  <= sync_2;
                stable_cnt <= '0;
            end else if (stable_done) begin
                clean_rows <= candidate;
            end else begin
                stable_cnt <= stable_cnt + 1'b1;
            end
        end
    end

    // A new value on the raw rows shows on clean_rows 2 + FILTER_CYCLES
    // cycles later when it holds that long. Two cycles go to the sync
    // flops and the rest to FILTER_CYCLES equal samples, the last of
    // which loads clean_rows

endmodule

`default_nettype wire

//--- rtl/keypad_scanner.sv
`timescale 1ns/1ps
`default_nettype none

module keypad_scanner
    import keypad_pkg::*;
(
    input  wire logic  clk,
    input  wire logic  nRST,
    input  wire rows_t clean_rows,
    output cols_t      cols,
    output logic       push,
    output key_char_t  push_char
);

    scan_state_t            state;
    scan_state_t            next_state;
    logic [DWELL_CNT_W-1:0] dwell_cnt;
    logic [1:0]             col_idx;
    logic                   dwell_end;
    logic                   rows_idle;
    key_code_t              code;
    key_char_t              decoded;

    // ------------------------------------------------------------------
    // Column drive
    // ------------------------------------------------------------------

    // One column low at a time, selected by col_idx
    assign cols = ~(cols_t'(1) << col_idx);

    assign dwell_end = (dwell_cnt == DWELL_CNT_W'(DWELL_CYCLES - 1));
    assign rows_idle = (clean_rows == '0);

    // ------------------------------------------------------------------
    // Layout table
    // ------------------------------------------------------------------

    assign code = {clean_rows, cols};

    // Row-major order, rows in the upper nibble, driven column low below.
    // Anything that is not exactly one row on the driven column gives 0
    always_comb begin
        case (code)
            8'h1E: decoded = "1";
            8'h1D: decoded = "2";
            8'h1B: decoded = "3";
            8'h17: decoded = "A";
            8'h2E: decoded = "4";
            8'h2D: decoded = "5";
            8'h2B: decoded = "6";
            8'h27: decoded = "B";
            8'h4E: decoded = "7";
            8'h4D: decoded = "8";
            8'h4B: decoded = "9";
            8'h47: decoded = "C";
            8'h8E: decoded = "*";
            8'h8D: decoded = "0";
            8'h8B: decoded = "#";
            8'h87: decoded = "D";
            default: decoded = '0;
        endcase
    end

    // ------------------------------------------------------------------
    // Press and release FSM
    // ------------------------------------------------------------------

    always_comb begin
        next_state = state;
        case (state)
            SCAN: begin
                // Rows are only trusted at the end of a dwell, once the
                // filter has caught up with the new column
                if (dwell_end && !rows_idle) begin
                    next_state = HELD;
                end
            end
            HELD: begin
                if (rows_idle) begin
                    next_state = RELEASE;
                end
            end
            RELEASE: begin
                if (!rows_idle) begin
                    next_state = HELD;
                end else if (dwell_end) begin
                    next_state = SCAN;
                end
            end
            default: next_state = SCAN;
        endcase
    end

    always_ff @(posedge clk, negedge nRST) begin
        if (!nRST) begin
            state     <= SCAN;
            dwell_cnt <= '0;
            col_idx   <= '0;
            push      <= 1'b0;
        end else begin
            state <= next_state;
            push  <= (state == SCAN) && dwell_end && (decoded != '0);

            // The dwell counter runs in SCAN and RELEASE and waits in HELD
            if (state == HELD || next_state == HELD || dwell_end) begin
                dwell_cnt <= '0;
            end else begin
                dwell_cnt <= dwell_cnt + 1'b1;
            end

            // The column moves on after an empty dwell in SCAN, or after
            // the release dwell, and stays frozen otherwise
            if (dwell_end && rows_idle && state != HELD) begin
                col_idx <= col_idx + 1'b1;
            end
        end
    end

    // Character register, loaded with the judged key
    always_ff @(posedge clk) begin
        if (state == SCAN && dwell_end) begin
            push_char <= decoded;
        end
    end

endmodule

`default_nettype wire

//--- rtl/keypad_top.sv
`timescale 1ns/1ps
`default_nettype none

module keypad_top
    import keypad_pkg::*;
(
    input  wire logic  clk,
    input  wire logic  nRST,
    input  wire rows_t rows,
    output cols_t      cols,
    output logic       key_valid,
    output key_char_t  key_char,
    input  wire logic  credit_return,
    output logic       overflow
);

    rows_t     clean_rows;
    logic      push;
    key_char_t push_char;

    // ------------------------------------------------------------------
    // Row conditioning
    // ------------------------------------------------------------------

    keypad_row_filter u_filter (
        .clk        (clk),
        .nRST       (nRST),
        .rows       (rows),
        .clean_rows (clean_rows)
    );

    // ------------------------------------------------------------------
    // Scanning and decode
    // ------------------------------------------------------------------

    keypad_scanner u_scanner (
        .clk        (clk),
        .nRST       (nRST),
        .clean_rows (clean_rows),
        .cols       (cols),
        .push       (push),
        .push_char  (push_char)
    );

    // ------------------------------------------------------------------
    // Character queue toward the consumer
    // ------------------------------------------------------------------

    // The queue takes every push and drops it when full
    key_queue u_queue (
        .clk           (clk),
        .nRST          (nRST),
        .push          (push),
        .push_char     (push_char),
        .key_valid     (key_valid),
        .key_char      (key_char),
        .credit_return (credit_return),
        .overflow      (overflow)
    );

endmodule

`default_nettype wire

//--- sim/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
    output logic clk
);

    // Half of the 20 ns period
    localparam int HALF_PERIOD = 10;

    initial begin
        clk = 1'b0;
        forever begin
            #HALF_PERIOD clk = ~clk;
        end
    end

endmodule

`default_nettype wire

//--- sim/tb_keypad.sv
`timescale 1ns/1ps
`default_nettype none

module tb_keypad
    import keypad_pkg::*;
();

    // 16 singles, 2 in the hold test, 2 in the column test, 4 + 8 with credits held
    localparam int NUM_PRESSES    = 32;
    localparam int TIMEOUT_CYCLES = 200 * NUM_PRESSES + 2000;
    localparam int PRESS_HOLD     = 80;
    localparam int RELEASE_IDLE   = 40;

    logic        clk;
    logic        nRST;
    rows_t       rows;
    cols_t       cols;
    logic        key_valid;
    key_char_t   key_char;
    logic        credit_return = 1'b0;
    logic        overflow;

    logic [15:0] pressed;
    logic        withhold;
    logic        return_now    = 1'b0;
    integer      seed;
    int          rx_count      = 0;
    int          cycle_count   = 0;
    int          delay_table[64];
    int          return_delays[$];
    key_char_t   expect_q[$];
    key_char_t   exp_char;

    tb_clock u_clock (
        .clk (clk)
    );

    keypad_top UUT (
        .clk           (clk),
        .nRST          (nRST),
        .rows          (rows),
        .cols          (cols),
        .key_valid     (key_valid),
        .key_char      (key_char),
        .credit_return (credit_return),
        .overflow      (overflow)
    );

    // ------------------------------------------------------------------
    // Keypad matrix, key r*4+c joins row r to column c
    // ------------------------------------------------------------------

    always_comb begin
        rows = '0;
        for (int r = 0; r < 4; r++) begin
            for (int c = 0; c < 4; c++) begin
                if (pressed[r*4 + c] && !cols[c]) begin
                    rows[r] = 1'b1;
                end
            end
        end
    end

    // ------------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------------

    function automatic key_char_t layout_char(input int idx);
        string layout;
        layout = "123A456B789C*0#D";
        return key_char_t'(layout[idx]);
    endfunction

    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % $unsigned(n));
    endfunction

    task automatic check_equal(input int got, input int expected, input string what);
        if (got != expected) begin
            $display("FAIL %0t ns: %s is 0x%0h, expected 0x%0h", $time, what, got, expected);
            $display("Regression failed");
            $fatal(1);
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    // Moves one key, sometimes with a short bounce before it settles
    task automatic move_key(input int idx, input logic down);
        int blips;
        blips = rand_below(3);
        if (blips != 0) begin
            pressed[idx] = down;
            next_cycle();
            pressed[idx] = !down;
            repeat (blips) next_cycle();
        end
        pressed[idx] = down;
    endtask

    task automatic wait_drained();
        while (expect_q.size() != 0) begin
            next_cycle();
        end
    endtask

    task automatic settle_credits();
        wait_drained();
        while (return_delays.size() != 0) begin
            next_cycle();
        end
        repeat (2) next_cycle();
    endtask

    // Press, wait for the character, then release
    task automatic single_press(input int idx);
        expect_q.push_back(layout_char(idx));
        move_key(idx, 1'b1);
        wait_drained();
        repeat (rand_below(20)) next_cycle();
        move_key(idx, 1'b0);
        repeat (RELEASE_IDLE) next_cycle();
    endtask

    // Press and release on fixed timing, for runs without credits
    task automatic tap_key(input int idx);
        move_key(idx, 1'b1);
        repeat (PRESS_HOLD) next_cycle();
        move_key(idx, 1'b0);
        repeat (RELEASE_IDLE) next_cycle();
    endtask

    // ------------------------------------------------------------------
    // Consumer, checks characters and returns credits
    // ------------------------------------------------------------------

    always @(negedge clk) begin
        if (nRST && key_valid && expect_q.size() == 0) begin
            $display("Character 0x%0h was sent at %0t ns while none was expected",
                     key_char, $time);
            $display("Regression failed");
            $fatal(1);
        end else begin
            if (nRST && key_valid) begin
                exp_char = expect_q.pop_front();
                check_equal(int'(key_char), int'(exp_char), "key_char");
                return_delays.push_back(delay_table[rx_count % 64]);
                rx_count++;
            end
            // Credits go back one at a time, each after its own delay
            return_now = 1'b0;
            if (!withhold && return_delays.size() != 0) begin
                if (return_delays[0] == 0) begin
                    return_now = 1'b1;
                    void'(return_delays.pop_front());
                end else begin
                    return_delays[0] = return_delays[0] - 1;
                end
            end
        end
    end

    always @(posedge clk) begin
        #1;
        credit_return = return_now;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("The run timed out after %0d cycles", TIMEOUT_CYCLES);
            $display("Regression failed");
            $fatal(1);
        end
    end

    // ------------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------------

    initial begin
        int order[16];
        int tmp;
        int j;
        int a;
        int b;
        int start;
        int col;
        int r1;
        int r2;

        seed     = 32'h9928_8657;
        nRST     = 1'b0;
        pressed  = '0;
        withhold = 1'b0;
        for (int i = 0; i < 64; i++) begin
            delay_table[i] = rand_below(21);
        end
        repeat (10) @(posedge clk);
        #1;
        nRST = 1'b1;
        check_equal(int'(cols), 14, "cols after reset");
        check_equal(int'(key_valid), 0, "key_valid after reset");
        check_equal(int'(overflow), 0, "overflow after reset");

        // All 16 keys once, in shuffled order
        for (int i = 0; i < 16; i++) begin
            order[i] = i;
        end
        for (int i = 15; i > 0; i--) begin
            j        = rand_below(i + 1);
            tmp      = order[i];
            order[i] = order[j];
            order[j] = tmp;
        end
        for (int i = 0; i < 16; i++) begin
            single_press(order[i]);
        end

        // Long hold, and a second key in another column pressed meanwhile
        a = rand_below(16);
        b = rand_below(16);
        while ((b % 4) == (a % 4)) begin
            b = rand_below(16);
        end
        start = rx_count;
        expect_q.push_back(layout_char(a));
        move_key(a, 1'b1);
        wait_drained();
        repeat (100 + rand_below(401)) next_cycle();
        move_key(b, 1'b1);
        repeat (PRESS_HOLD) next_cycle();
        check_equal(rx_count - start, 1, "characters while the first key is held");
        expect_q.push_back(layout_char(b));
        move_key(a, 1'b0);
        wait_drained();
        move_key(b, 1'b0);
        repeat (RELEASE_IDLE) next_cycle();

        // Two keys in one column decode to nothing
        col   = rand_below(4);
        r1    = rand_below(4);
        r2    = (r1 + 1 + rand_below(3)) % 4;
        start = rx_count;
        pressed[r1*4 + col] = 1'b1;
        pressed[r2*4 + col] = 1'b1;
        repeat (PRESS_HOLD) next_cycle();
        check_equal(rx_count - start, 0, "characters for two keys in one column");
        pressed[r1*4 + col] = 1'b0;
        pressed[r2*4 + col] = 1'b0;
        repeat (RELEASE_IDLE) next_cycle();
        single_press(rand_below(16));

        // Credits held back, the queue keeps what the credits do not cover
        settle_credits();
        withhold = 1'b1;
        start    = rx_count;
        repeat (4) begin
            j = rand_below(16);
            expect_q.push_back(layout_char(j));
            tap_key(j);
        end
        check_equal(rx_count - start, SINK_CREDITS, "characters sent without credits");
        withhold = 1'b0;
        wait_drained();
        check_equal(int'(overflow), 0, "overflow before the queue fills");

        // More presses than credits plus queue slots
        settle_credits();
        withhold = 1'b1;
        start    = rx_count;
        for (int i = 0; i < SINK_CREDITS + QUEUE_DEPTH + 2; i++) begin
            j = rand_below(16);
            if (i < SINK_CREDITS + QUEUE_DEPTH) begin
                expect_q.push_back(layout_char(j));
            end
            tap_key(j);
        end
        check_equal(rx_count - start, SINK_CREDITS, "characters sent without credits");
        check_equal(int'(overflow), 1, "overflow after a full queue");
        withhold = 1'b0;
        wait_drained();
        repeat (200) next_cycle();
        check_equal(rx_count - start, SINK_CREDITS + QUEUE_DEPTH, "characters delivered");
        check_equal(int'(overflow), 1, "overflow at the end");

        $display("Regression passed");
        $finish;
    end

endmodule

`default_nettype wire
